//--- verilog/pdu_gen_params.svh
`ifndef PDU_GEN_PARAMS_SVH
`define PDU_GEN_PARAMS_SVH

// stream beat geometry
`define PDU_DATA_WIDTH 512
`define PDU_EMPTY_WIDTH 6
`define PDU_FLIT_BYTES 64

// queue ids as they arrive in the metadata word
`define PDU_QUEUE_ID_WIDTH 32

// queue ids as they are kept in the descriptor
`define PDU_APP_IDX_WIDTH 8
`define PDU_FLOW_IDX_WIDTH 10

// byte and flit counters share one width
`define PDU_SIZE_WIDTH 16

`endif

//--- verilog/pkt_types_pkg.sv
`default_nettype none

`include "pdu_gen_params.svh"

package pkt_types_pkg;

    // one beat as written to the pcie packet buffer
    // data is already byte-reversed when it lands here
    typedef struct packed {
        logic [`PDU_DATA_WIDTH-1:0] data;
        logic                       sop;
        logic                       eop;
    } flit_lite_t;

    // 514 bits total

endpackage

`default_nettype wire

//--- verilog/meta_types_pkg.sv
`default_nettype none

`include "pdu_gen_params.svh"

package meta_types_pkg;

    // per-packet metadata that travels next to the stream
    typedef struct packed {
        logic [`PDU_QUEUE_ID_WIDTH-1:0] dsc_queue_id;
        logic [`PDU_QUEUE_ID_WIDTH-1:0] pkt_queue_id;
    } metadata_t;

    // descriptor written to the pcie metadata buffer at end of packet
    typedef struct packed {
        logic [`PDU_APP_IDX_WIDTH-1:0]  dsc_queue_id;
        logic [`PDU_FLOW_IDX_WIDTH-1:0] pkt_queue_id;
        // size_bytes already has the empty bytes of the last beat removed
        logic [`PDU_SIZE_WIDTH-1:0]     size_bytes;
        logic [`PDU_SIZE_WIDTH-1:0]     size_flits;
    } pkt_meta_t;

endpackage

`default_nettype wire

//--- verilog/flit_swapper.sv
`timescale 1ns/1ps
`default_nettype none

`include "pdu_gen_params.svh"

module flit_swapper (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          beat_keep,
    input  logic                          in_sop,
    input  logic                          in_eop,
    input  logic [`PDU_DATA_WIDTH-1:0]    in_data,
    output pkt_types_pkg::flit_lite_t     flit
);

    import pkt_types_pkg::*;

    localparam int NUM_BYTES = `PDU_FLIT_BYTES;

    // next flit, built from the incoming beat
    flit_lite_t beat_swapped;

    // byte 0 of the input lands in the top byte of the flit
    always_comb begin
        beat_swapped.data = '0;
        for (int i = 0; i < NUM_BYTES; i++) begin
            beat_swapped.data[(NUM_BYTES - 1 - i) * 8 +: 8] = in_data[i * 8 +: 8];
        end
        beat_swapped.sop = in_sop;
        beat_swapped.eop = in_eop;
    end

    // framing marks clear on reset, payload just loads on keep
    always_ff @(posedge clk) begin
        if (rst) begin
            flit.sop <= 1'b0;
            flit.eop <= 1'b0;
        end else if (beat_keep) begin
            flit <= beat_swapped;
        end
    end

endmodule

`default_nettype wire

//--- verilog/pdu_sizer.sv
`timescale 1ns/1ps
`default_nettype none

`include "pdu_gen_params.svh"

module pdu_sizer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          beat_keep,
    input  logic                          in_sop,
    input  logic                          in_eop,
    input  logic [`PDU_EMPTY_WIDTH-1:0]   in_empty,
    input  meta_types_pkg::metadata_t     in_meta_data,
    output meta_types_pkg::pkt_meta_t     desc
);

    import meta_types_pkg::*;

    localparam int SW = `PDU_SIZE_WIDTH;
    localparam int EW = `PDU_EMPTY_WIDTH;

    logic [SW-1:0] byte_cnt;
    logic [SW-1:0] flit_cnt;

    logic [SW-1:0] byte_base;
    logic [SW-1:0] flit_base;
    logic [SW-1:0] byte_next;
    logic [SW-1:0] flit_next;

    pkt_meta_t desc_next;

    // a sop beat starts counting from zero, whatever was left over
    assign byte_base = in_sop ? '0 : byte_cnt;
    assign flit_base = in_sop ? '0 : flit_cnt;

    // every kept beat is counted as a full flit
    assign byte_next = byte_base + SW'(`PDU_FLIT_BYTES);
    assign flit_next = flit_base + SW'(1);

    always_comb begin
        desc_next.dsc_queue_id = in_meta_data.dsc_queue_id[`PDU_APP_IDX_WIDTH-1:0];
        desc_next.pkt_queue_id = in_meta_data.pkt_queue_id[`PDU_FLOW_IDX_WIDTH-1:0];
        // the last beat only carries 64 - empty valid bytes
        desc_next.size_bytes   = byte_next - {{(SW - EW){1'b0}}, in_empty};
        desc_next.size_flits   = flit_next;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_cnt <= '0;
            flit_cnt <= '0;
        end else if (beat_keep) begin
            byte_cnt <= byte_next;
            flit_cnt <= flit_next;
        end
    end

    // descriptor only changes on the eop beat
    always_ff @(posedge clk) begin
        if (beat_keep && in_eop) begin
            desc <= desc_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/pdu_buf_writer.sv
`timescale 1ns/1ps
`default_nettype none

module pdu_buf_writer (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  logic in_meta_valid,
    input  logic in_sop,
    input  logic in_eop,
    input  logic pkt_buf_ready,
    input  logic meta_buf_ready,
    output logic in_ready,
    output logic beat_keep,
    output logic pkt_wr_en,
    output logic meta_wr_en,
    output logic in_meta_ready
);

    logic consume;
    logic pkt_open;

    // both buffers must have room, each keeps one slot of slack
    // for the beat already sitting in the output registers
    assign in_ready = pkt_buf_ready & meta_buf_ready;

    // a beat needs its metadata to be present as well
    assign consume = in_valid & in_meta_valid & in_ready;

    // beats outside a packet without sop are dropped here
    assign beat_keep = consume & (in_sop | pkt_open);

    // packet framing state
    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_open <= 1'b0;
        end else if (beat_keep) begin
            if (in_eop) begin
                // covers the single-beat packet too
                pkt_open <= 1'b0;
            end else if (in_sop) begin
                pkt_open <= 1'b1;
            end
        end
    end

    // strobes line up with the registered flit and descriptor
    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_wr_en     <= 1'b0;
            meta_wr_en    <= 1'b0;
            in_meta_ready <= 1'b0;
        end else begin
            pkt_wr_en     <= beat_keep;
            meta_wr_en    <= beat_keep & in_eop;
            // metadata is released together with the descriptor write
            in_meta_ready <= beat_keep & in_eop;
        end
    end

endmodule

`default_nettype wire

//--- verilog/pdu_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "pdu_gen_params.svh"

module pdu_gen (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            in_sop,
    input  logic                            in_eop,
    input  logic [`PDU_DATA_WIDTH-1:0]      in_data,
    input  logic [`PDU_EMPTY_WIDTH-1:0]     in_empty,
    input  logic                            in_valid,
    output logic                            in_ready,
    input  logic                            in_meta_valid,
    input  var meta_types_pkg::metadata_t   in_meta_data,
    output logic                            in_meta_ready,
    output var pkt_types_pkg::flit_lite_t   pcie_pkt_buf_wr_data,
    output logic                            pcie_pkt_buf_wr_en,
    input  logic                            pcie_pkt_buf_in_ready,
    output var meta_types_pkg::pkt_meta_t   pcie_meta_buf_wr_data,
    output logic                            pcie_meta_buf_wr_en,
    input  logic                            pcie_meta_buf_in_ready
);

    // shared load enable for both data paths
    logic beat_keep;

    // admission, framing and write strobes
    pdu_buf_writer u_writer (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_meta_valid  (in_meta_valid),
        .in_sop         (in_sop),
        .in_eop         (in_eop),
        .pkt_buf_ready  (pcie_pkt_buf_in_ready),
        .meta_buf_ready (pcie_meta_buf_in_ready),
        .in_ready       (in_ready),
        .beat_keep      (beat_keep),
        .pkt_wr_en      (pcie_pkt_buf_wr_en),
        .meta_wr_en     (pcie_meta_buf_wr_en),
        .in_meta_ready  (in_meta_ready)
    );

    // byte-reversed flit towards the packet buffer
    flit_swapper u_swapper (
        .clk       (clk),
        .rst       (rst),
        .beat_keep (beat_keep),
        .in_sop    (in_sop),
        .in_eop    (in_eop),
        .in_data   (in_data),
        .flit      (pcie_pkt_buf_wr_data)
    );

    // descriptor towards the metadata buffer
    pdu_sizer u_sizer (
        .clk          (clk),
        .rst          (rst),
        .beat_keep    (beat_keep),
        .in_sop       (in_sop),
        .in_eop       (in_eop),
        .in_empty     (in_empty),
        .in_meta_data (in_meta_data),
        .desc         (pcie_meta_buf_wr_data)
    );

endmodule

`default_nettype wire

//--- test/pdu_gen_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module pdu_gen_asserts (
    input logic clk,
    input logic rst,
    input logic in_ready,
    input logic pkt_wr_en,
    input logic meta_wr_en,
    input logic in_meta_ready,
    input logic pkt_eop
);

    // failed checks so far
    int fail_count = 0;

    // strobes come out of reset low
    strobes_low_after_reset: assert property (
        @(posedge clk) rst |=> (!pkt_wr_en && !meta_wr_en && !in_meta_ready)
    ) else begin
        $error("write strobe high in the cycle after reset");
        fail_count++;
    end

    // a descriptor is only written next to the last flit of a packet
    desc_with_last_flit: assert property (
        @(posedge clk) disable iff (rst) meta_wr_en |-> (pkt_wr_en && pkt_eop)
    ) else begin
        $error("descriptor write without an eop flit write");
        fail_count++;
    end

    // metadata release follows the descriptor write
    meta_ready_is_desc_write: assert property (
        @(posedge clk) disable iff (rst) in_meta_ready == meta_wr_en
    ) else begin
        $error("in_meta_ready differs from the descriptor write strobe");
        fail_count++;
    end

    // a stalled input cannot produce a write
    no_write_after_stall: assert property (
        @(posedge clk) disable iff (rst) !in_ready |=> !pkt_wr_en
    ) else begin
        $error("packet buffer written after a cycle with in_ready low");
        fail_count++;
    end

endmodule

bind pdu_gen pdu_gen_asserts u_asserts (
    .clk           (clk),
    .rst           (rst),
    .in_ready      (in_ready),
    .pkt_wr_en     (pcie_pkt_buf_wr_en),
    .meta_wr_en    (pcie_meta_buf_wr_en),
    .in_meta_ready (in_meta_ready),
    .pkt_eop       (pcie_pkt_buf_wr_data.eop)
);

`default_nettype wire

//--- test/pdu_gen_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pdu_gen_params.svh"

module pdu_gen_tb;

    import pkt_types_pkg::*;
    import meta_types_pkg::*;

    localparam int DW = `PDU_DATA_WIDTH;
    localparam int EW = `PDU_EMPTY_WIDTH;
    localparam int SW = `PDU_SIZE_WIDTH;
    localparam int WAIT_LIMIT = 200;

    logic clk = 1'b0;
    logic rst;
    logic in_sop;
    logic in_eop;
    logic [DW-1:0] in_data;
    logic [EW-1:0] in_empty;
    logic in_valid;
    logic in_ready;
    logic in_meta_valid;
    metadata_t in_meta_data;
    logic in_meta_ready;
    flit_lite_t pcie_pkt_buf_wr_data;
    logic pcie_pkt_buf_wr_en;
    logic pkt_buf_ready;
    pkt_meta_t pcie_meta_buf_wr_data;
    logic pcie_meta_buf_wr_en;
    logic meta_buf_ready;

    // expected writes in order
    flit_lite_t exp_flits[$];
    pkt_meta_t exp_descs[$];

    int data_errs = 0;
    int proto_errs = 0;
    int timeouts = 0;
    int meta_pulses = 0;
    int pkts_sent = 0;
    logic abort = 1'b0;
    logic pkt_open_model = 1'b0;
    logic [2:0] phase = 3'd0;
    logic [31:0] lcg_state = 32'h8bbecb8d;

    pdu_gen uut (
        .clk                    (clk),
        .rst                    (rst),
        .in_sop                 (in_sop),
        .in_eop                 (in_eop),
        .in_data                (in_data),
        .in_empty               (in_empty),
        .in_valid               (in_valid),
        .in_ready               (in_ready),
        .in_meta_valid          (in_meta_valid),
        .in_meta_data           (in_meta_data),
        .in_meta_ready          (in_meta_ready),
        .pcie_pkt_buf_wr_data   (pcie_pkt_buf_wr_data),
        .pcie_pkt_buf_wr_en     (pcie_pkt_buf_wr_en),
        .pcie_pkt_buf_in_ready  (pkt_buf_ready),
        .pcie_meta_buf_wr_data  (pcie_meta_buf_wr_data),
        .pcie_meta_buf_wr_en    (pcie_meta_buf_wr_en),
        .pcie_meta_buf_in_ready (meta_buf_ready)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [DW-1:0] random_beat();
        logic [DW-1:0] d;
        d = '0;
        for (int i = 0; i < DW / 32; i++) begin
            d = {d[DW-33:0], next_rand()};
        end
        return d;
    endfunction

    // readies for the coming edge, one pattern bit per phase and buffer
    task automatic drive_readies(input logic [15:0] bp);
        pkt_buf_ready  <= ~bp[{1'b0, phase}];
        meta_buf_ready <= ~bp[{1'b1, phase}];
        phase = phase + 3'd1;
    endtask

    // holds one beat on the bus until it is consumed
    task automatic send_beat(input logic [DW-1:0] d, input logic sop, input logic eop,
                             input logic [EW-1:0] emp, input logic [15:0] bp);
        int waited;
        logic took;
        flit_lite_t f;
        waited = 0;
        took = 1'b0;
        in_data  <= d;
        in_sop   <= sop;
        in_eop   <= eop;
        in_empty <= emp;
        in_valid <= 1'b1;
        drive_readies(bp);
        while (!took && !abort) begin
            @(negedge clk);
            took = in_ready;
            @(posedge clk);
            if (!took) begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    timeouts++;
                    abort = 1'b1;
                    $display("timeout at %0t: beat was never accepted", $time);
                end else begin
                    drive_readies(bp);
                end
            end
        end
        // only beats that start a packet or sit inside one are written
        if (took && (sop || pkt_open_model)) begin
            f.data = {<<8{d}};
            f.sop = sop;
            f.eop = eop;
            exp_flits.push_back(f);
            pkt_open_model = !eop;
        end
    endtask

    task automatic send_packet(input logic [31:0] dsc, input logic [31:0] pkt, input int flits,
                               input int emp, input int stray, input logic [15:0] bp,
                               input int exp_bytes);
        pkt_meta_t d_exp;
        in_meta_data  <= {dsc, pkt};
        in_meta_valid <= 1'b1;
        // a stray beat has eop but no sop and must vanish
        if (stray != 0) begin
            send_beat(random_beat(), 1'b0, 1'b1, '0, bp);
        end
        for (int i = 0; i < flits && !abort; i++) begin
            send_beat(random_beat(), i == 0, i == flits - 1,
                      (i == flits - 1) ? EW'(emp) : '0, bp);
        end
        d_exp.dsc_queue_id = dsc[`PDU_APP_IDX_WIDTH-1:0];
        d_exp.pkt_queue_id = pkt[`PDU_FLOW_IDX_WIDTH-1:0];
        d_exp.size_bytes   = SW'(exp_bytes);
        d_exp.size_flits   = SW'(flits);
        if (!abort) begin
            exp_descs.push_back(d_exp);
            pkts_sent++;
        end
    endtask

    task automatic check_flit();
        flit_lite_t e;
        flit_expected: assert (exp_flits.size() > 0) else begin
            proto_errs++;
            $display("packet buffer written at %0t with no flit expected", $time);
        end
        if (exp_flits.size() > 0) begin
            e = exp_flits.pop_front();
            flit_data_ok: assert (pcie_pkt_buf_wr_data.data == e.data) else begin
                data_errs++;
                $display("FAIL %0t pcie_pkt_buf_wr_data.data expected %h got %h",
                         $time, e.data, pcie_pkt_buf_wr_data.data);
            end
            flit_sop_ok: assert (pcie_pkt_buf_wr_data.sop == e.sop) else begin
                data_errs++;
                $display("FAIL %0t pcie_pkt_buf_wr_data.sop expected %b got %b",
                         $time, e.sop, pcie_pkt_buf_wr_data.sop);
            end
            flit_eop_ok: assert (pcie_pkt_buf_wr_data.eop == e.eop) else begin
                data_errs++;
                $display("FAIL %0t pcie_pkt_buf_wr_data.eop expected %b got %b",
                         $time, e.eop, pcie_pkt_buf_wr_data.eop);
            end
        end
    endtask

    task automatic check_desc();
        pkt_meta_t e;
        desc_expected: assert (exp_descs.size() > 0) else begin
            proto_errs++;
            $display("metadata buffer written at %0t with no descriptor expected", $time);
        end
        if (exp_descs.size() > 0) begin
            e = exp_descs.pop_front();
            desc_ok: assert (pcie_meta_buf_wr_data == e) else begin
                data_errs++;
                $display("FAIL %0t pcie_meta_buf_wr_data expected %h got %h",
                         $time, e, pcie_meta_buf_wr_data);
            end
        end
    endtask

    // outputs are sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            ready_follows: assert (in_ready == (pkt_buf_ready & meta_buf_ready)) else begin
                proto_errs++;
                $display("FAIL %0t in_ready expected %b got %b",
                         $time, pkt_buf_ready & meta_buf_ready, in_ready);
            end
            if (pcie_pkt_buf_wr_en) begin
                check_flit();
            end
            if (pcie_meta_buf_wr_en) begin
                check_desc();
            end
            if (in_meta_ready) begin
                meta_pulses++;
            end
        end
    end

    initial begin
        int fd;
        int n;
        int waited;
        int flits;
        int emp;
        int stray;
        int exp_bytes;
        string line;
        logic [31:0] dsc;
        logic [31:0] pkt;
        logic [15:0] bp;
        rst            <= 1'b1;
        in_sop         <= 1'b0;
        in_eop         <= 1'b0;
        in_data        <= '0;
        in_empty       <= '0;
        in_valid       <= 1'b0;
        in_meta_valid  <= 1'b0;
        in_meta_data   <= '0;
        pkt_buf_ready  <= 1'b1;
        meta_buf_ready <= 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        fd = $fopen("test/pdu_gen_golden.txt", "r");
        if (fd == 0) begin
            proto_errs++;
            abort = 1'b1;
            $display("cannot open test/pdu_gen_golden.txt");
        end else begin
            while (!abort && $fgets(line, fd) > 0) begin
                if (line.len() > 1 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%h %h %d %d %d %h %d",
                                dsc, pkt, flits, emp, stray, bp, exp_bytes);
                    golden_line_ok: assert (n == 7 && exp_bytes == 64 * flits - emp) else begin
                        proto_errs++;
                        $display("golden line is malformed or inconsistent: %s", line);
                    end
                    if (n == 7) begin
                        send_packet(dsc, pkt, flits, emp, stray, bp, exp_bytes);
                    end
                end
            end
            $fclose(fd);
        end
        in_valid       <= 1'b0;
        in_meta_valid  <= 1'b0;
        pkt_buf_ready  <= 1'b1;
        meta_buf_ready <= 1'b1;

        // drain the writes still in flight
        waited = 0;
        while (!abort && (exp_flits.size() > 0 || exp_descs.size() > 0)) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                timeouts++;
                abort = 1'b1;
                $display("timeout at %0t: %0d flits and %0d descriptors never written",
                         $time, exp_flits.size(), exp_descs.size());
            end
        end
        repeat (4) @(posedge clk);
        pulse_count_ok: assert (abort || meta_pulses == pkts_sent) else begin
            proto_errs++;
            $display("FAIL %0t in_meta_ready pulses expected %0d got %0d",
                     $time, pkts_sent, meta_pulses);
        end
        $display("errors: data %0d, protocol %0d, timeout %0d, assertion %0d",
                 data_errs, proto_errs, timeouts, uut.u_asserts.fail_count);
        if (data_errs == 0 && proto_errs == 0 && timeouts == 0
                && uut.u_asserts.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- pdu_gen.f
+incdir+verilog
verilog/pkt_types_pkg.sv
verilog/meta_types_pkg.sv
verilog/flit_swapper.sv
verilog/pdu_sizer.sv
verilog/pdu_buf_writer.sv
verilog/pdu_gen.sv
test/pdu_gen_asserts.sv
test/pdu_gen_tb.sv

//--- Makefile
# Verilator build and run for pdu_gen

VERILATOR ?= verilator
TOP       ?= pdu_gen_tb
RTL_TOP   ?= pdu_gen
FILELIST  ?= pdu_gen.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?=

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q '>>> PASS' $(LOG); then echo "simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/pdu_gen_golden.txt
# dsc_queue_id(hex) pkt_queue_id(hex) flits empty stray(0/1) backpressure(hex) size_bytes
# backpressure bit p drops the packet buffer ready in phase p, bit 8+p the metadata buffer ready
00000001 00000002 1 0 0 0000 64
deadbeef 12345678 1 63 0 0000 1
000000ff 000003ff 2 0 0 0000 128
0000a5a5 00005a5a 3 17 0 0000 175
ffffffff ffffffff 4 1 0 0000 255
12345601 abcde402 2 32 1 0000 96
00000010 00000400 1 5 1 0000 59
87654321 0badf00d 5 0 0 0011 320
00000abc 00000def 3 60 0 0500 132
7fffffff 80000000 6 9 0 8181 375
00000003 00000c03 1 0 0 0f0f 64
13579bdf 2468ace0 4 48 1 00f0 208
c0ffee00 facade11 2 2 0 3c00 126
00000100 00000800 1 12 0 1248 52
55555555 aaaaaaaa 6 63 0 0303 321
0000007f 000001ff 3 0 1 8080 192
11111111 22222222 2 40 0 4400 88
33333333 44444444 5 31 0 0022 289
00badbad 00c0ffee 1 1 1 0101 63
66666666 77777777 4 0 0 0000 256
99999999 88888888 3 3 0 0e00 189
0000beef 0000cafe 2 16 0 00e0 112
01010101 02020202 1 32 0 2121 32
f0f0f0f0 0f0f0f0f 6 0 1 0000 384
00000042 00000242 2 62 0 1818 66
abcdef01 23456789 5 10 0 0606 310
00000000 00000000 1 0 0 0000 64
fedcba98 76543210 3 33 0 c000 159
0000ffff 0000ffff 4 7 1 000c 249
10203040 50607080 2 0 0 6000 128
00000077 00000333 1 20 0 0000 44
99990000 00009999 6 24 0 1111 360
0a0b0c0d 0e0f1011 3 50 0 2000 142
00001234 00005678 1 63 1 0000 1
77777777 11111111 2 8 0 0440 120
